/* compile.f */
+incdir+include
logic/mips_isa_pkg.sv
logic/cpu_ctrl_pkg.sv
logic/fetch_unit.sv
logic/inst_decoder.sv
logic/regfile.sv
logic/alu.sv
logic/data_ram.sv
logic/single_cycle_cpu.sv
verif/cpu_asserts.sv
verif/cpu_tb.sv

/* verif/program_golden.txt */
# P word-index instruction, C run length in cycles (decimal)
# R register expected-value, M data-word-index expected-value, all hex
P 00 24010007
P 01 2402FFFD
P 02 00221821
P 03 00222023
P 04 0041282A
P 05 00203027
P 06 00C2382A
P 07 00444024
P 08 00244825
P 09 00415026
P 0a 00015900
P 0b 00026702
P 0c 3C0D1234
P 0d 24000055
P 0e AC010000
P 0f AC0D0008
P 10 AC6A0010
P 11 8C0E0008
P 12 8C6F0010
P 13 8C100000
P 14 10300002
P 15 24110011
P 16 10220002
P 17 24120012
P 18 14220002
P 19 24130013
P 1a 0800001C
P 1b 24140014
P 1c 24150015
P 1d 0800001D
C 40
R 00 00000000
R 01 00000007
R 02 FFFFFFFD
R 03 00000004
R 04 0000000A
R 05 00000001
R 06 FFFFFFF8
R 07 00000001
R 08 00000008
R 09 0000000F
R 0a FFFFFFFA
R 0b 00000070
R 0c 0000000F
R 0d 12340000
R 0e 12340000
R 0f FFFFFFFA
R 10 00000007
R 11 00000000
R 12 00000012
R 13 00000000
R 14 00000000
R 15 00000015
M 00 00000007
M 02 12340000
M 05 FFFFFFFA

/* verif/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb;

    localparam int    reset_cycles = 10;
    localparam string golden_path  = "verif/program_golden.txt";

    logic                clk;
    logic                resetn;
    logic                imem_wen;
    logic [`IMEM_AW-1:0] imem_waddr;
    logic [31:0]         imem_wdata;
    logic [4:0]          rf_addr;
    logic [31:0]         mem_addr;
    logic [31:0]         rf_data;
    logic [31:0]         mem_data;
    logic [31:0]         cpu_pc;
    logic [31:0]         cpu_inst;

    logic [31:0] prog_words [0:`IMEM_DEPTH-1];
    int          prog_count;
    int          last_index;
    int          run_len;
    int          cycle_limit;
    int          cycle_count;
    int          error_count;
    int          assert_fails;
    logic [31:0] reg_num [$];
    logic [31:0] reg_exp [$];
    logic [31:0] mem_word [$];
    logic [31:0] mem_exp [$];

    single_cycle_cpu single_cycle_cpu_inst (
        .clk        (clk),
        .resetn     (resetn),
        .imem_wen   (imem_wen),
        .imem_waddr (imem_waddr),
        .imem_wdata (imem_wdata),
        .rf_addr    (rf_addr),
        .mem_addr   (mem_addr),
        .rf_data    (rf_data),
        .mem_data   (mem_data),
        .cpu_pc     (cpu_pc),
        .cpu_inst   (cpu_inst)
    );

    bind single_cycle_cpu cpu_asserts cpu_asserts_inst (
        .clk     (clk),
        .resetn  (resetn),
        .pc      (pc),
        .inst    (inst),
        .dm_wen  (dm_wen),
        .rf_addr (rf_addr),
        .rf_data (rf_data)
    );

    always #20 clk = ~clk;    // 40 ns period

    // Run limit covers load, reset, run and the readback
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Run stopped after %0d cycles without reaching the end", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    endtask

    task automatic read_golden();
        int               fd;
        int               code;
        logic [7:0]       tag;
        logic [31:0]      field_a;
        logic [31:0]      field_b;
        logic [8*128-1:0] rest;
        fd = $fopen(golden_path, "r");
        if (fd == 0) begin
            $display("Could not open the golden file %s", golden_path);
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", tag);
            if (code == 1) begin
                case (tag)
                    "#": code = $fgets(rest, fd);    // Column notes
                    "P": begin
                        code = $fscanf(fd, "%h %h", field_a, field_b);
                        prog_words[field_a[`IMEM_AW-1:0]] = field_b;
                        prog_count++;
                        if (int'(field_a) > last_index) begin
                            last_index = int'(field_a);
                        end
                    end
                    "C": code = $fscanf(fd, "%d", run_len);
                    "R": begin
                        code = $fscanf(fd, "%h %h", field_a, field_b);
                        reg_num.push_back(field_a);
                        reg_exp.push_back(field_b);
                    end
                    "M": begin
                        code = $fscanf(fd, "%h %h", field_a, field_b);
                        mem_word.push_back(field_a);
                        mem_exp.push_back(field_b);
                    end
                    default: begin
                        $display("Golden file holds a line with unknown tag %c", tag);
                        error_count++;
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    task automatic load_program();
        for (int i = 0; i <= last_index; i++) begin
            @(negedge clk);
            imem_wen   = 1'b1;
            imem_waddr = i[`IMEM_AW-1:0];
            imem_wdata = prog_words[i];
        end
        @(negedge clk);
        imem_wen = 1'b0;
    endtask

    // PC parked at the reset address, first word already visible
    task automatic check_reset_state();
        repeat (reset_cycles) begin
            @(negedge clk);
            if (cpu_pc !== `STARTADDR) begin
                report_mismatch("reset pc", `STARTADDR, cpu_pc);
            end
            if (cpu_inst !== prog_words[0]) begin
                report_mismatch("reset inst", prog_words[0], cpu_inst);
            end
        end
        resetn = 1'b1;
    endtask

    task automatic check_results();
        logic [31:0] final_pc;
        final_pc = `STARTADDR + 32'(last_index * 4);    // Program ends in a jump to itself
        if (cpu_pc !== final_pc) begin
            report_mismatch("final pc", final_pc, cpu_pc);
        end
        foreach (reg_num[i]) begin
            @(negedge clk);
            rf_addr = reg_num[i][4:0];
            #1;
            if (rf_data !== reg_exp[i]) begin
                report_mismatch($sformatf("register r%0d", reg_num[i]), reg_exp[i], rf_data);
            end
        end
        foreach (mem_word[i]) begin
            @(negedge clk);
            mem_addr = mem_word[i] << 2;    // Word index to byte address
            #1;
            if (mem_data !== mem_exp[i]) begin
                report_mismatch($sformatf("memory word %0d", mem_word[i]), mem_exp[i], mem_data);
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        resetn      = 1'b0;
        imem_wen    = 1'b0;
        imem_waddr  = '0;
        imem_wdata  = 32'd0;
        rf_addr     = 5'd0;
        mem_addr    = 32'd0;
        prog_count  = 0;
        last_index  = 0;
        run_len     = 0;
        cycle_count = 0;
        error_count = 0;
        read_golden();
        cycle_limit = last_index + 2 + reset_cycles + run_len + 50;
        if (prog_count == 0) begin
            $display("Golden file holds no program words, so nothing was run");
            error_count++;
        end else begin
            load_program();
            check_reset_state();
            repeat (run_len) @(negedge clk);
            check_results();
        end
        assert_fails = single_cycle_cpu_inst.cpu_asserts_inst.fail_count;
        $display("Checks done: %0d errors, %0d assertion failures", error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verif/cpu_asserts.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_asserts (
    input logic        clk,
    input logic        resetn,
    input logic [31:0] pc,
    input logic [31:0] inst,
    input logic        dm_wen,
    input logic [4:0]  rf_addr,
    input logic [31:0] rf_data
);

    int fail_count = 0;    // Read by the testbench at the end

    pc_aligned: assert property (@(posedge clk) disable iff (!resetn) pc[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("PC %h is not word aligned", pc);
        end

    pc_held_in_reset: assert property (@(posedge clk) !resetn |=> pc == `STARTADDR)
        else begin
            fail_count++;
            $error("PC %h differs from the reset address after a reset cycle", pc);
        end

    zero_reg_reads_zero: assert property (@(posedge clk) rf_addr == 5'd0 |-> rf_data == 32'd0)
        else begin
            fail_count++;
            $error("Register zero reads %h on the display port", rf_data);
        end

    // 6'b101011 is the SW primary opcode
    store_only_on_sw: assert property (@(posedge clk) dm_wen |-> inst[31:26] == 6'b101011)
        else begin
            fail_count++;
            $error("Data memory written by instruction %h", inst);
        end

endmodule

/* logic/single_cycle_cpu.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module single_cycle_cpu (
    input  logic               clk,
    input  logic               resetn,
    input  logic               imem_wen,
    input  logic [`IMEM_AW-1:0] imem_waddr,
    input  logic [31:0]        imem_wdata,
    input  logic [4:0]         rf_addr,
    input  logic [31:0]        mem_addr,
    output logic [31:0]        rf_data,
    output logic [31:0]        mem_data,
    output logic [31:0]        cpu_pc,
    output logic [31:0]        cpu_inst
);

    logic [31:0]           pc;
    logic [31:0]           inst;
    logic [4:0]            rs;
    logic [4:0]            rt;
    logic [4:0]            rd;
    logic [4:0]            sa;
    logic [15:0]           imm;
    cpu_ctrl_pkg::alu_op_e alu_op;
    cpu_ctrl_pkg::pc_sel_e pc_sel;
    logic                  src1_is_sa;
    logic                  src2_is_imm;
    logic                  rf_wen;
    logic                  wdest_rd;
    logic                  wb_from_mem;
    logic                  mem_wen;
    logic [31:0]           rs_value;
    logic [31:0]           rt_value;
    logic [31:0]           alu_src1;
    logic [31:0]           alu_src2;
    logic [31:0]           alu_result;
    logic [4:0]            rf_waddr;
    logic [31:0]           rf_wdata;
    logic                  dm_wen;
    logic [31:0]           dm_rdata;

    fetch_unit fetch_unit_inst (
        .clk        (clk),
        .resetn     (resetn),
        .imem_wen   (imem_wen),
        .imem_waddr (imem_waddr),
        .imem_wdata (imem_wdata),
        .pc_sel     (pc_sel),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .pc         (pc),
        .inst       (inst)
    );

    inst_decoder inst_decoder_inst (
        .inst        (inst),
        .rs          (rs),
        .rt          (rt),
        .rd          (rd),
        .sa          (sa),
        .imm         (imm),
        .alu_op      (alu_op),
        .src1_is_sa  (src1_is_sa),
        .src2_is_imm (src2_is_imm),
        .rf_wen      (rf_wen),
        .wdest_rd    (wdest_rd),
        .wb_from_mem (wb_from_mem),
        .mem_wen     (mem_wen),
        .pc_sel      (pc_sel)
    );

    regfile regfile_inst (
        .clk       (clk),
        .resetn    (resetn),
        .wen       (rf_wen),    // Blocked in reset inside the regfile
        .raddr1    (rs),
        .raddr2    (rt),
        .waddr     (rf_waddr),
        .wdata     (rf_wdata),
        .rdata1    (rs_value),
        .rdata2    (rt_value),
        .test_addr (rf_addr),
        .test_data (rf_data)
    );

    // Operand muxes
    assign alu_src1 = src1_is_sa ? {27'd0, sa} : rs_value;
    assign alu_src2 = src2_is_imm ? {{16{imm[15]}}, imm} : rt_value;

    alu alu_inst (
        .alu_op (alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    assign dm_wen = mem_wen & resetn;    // No stores during reset

    data_ram data_ram_inst (
        .clk       (clk),
        .wen       (dm_wen),
        .addr      (alu_result[`DMEM_AW+1:2]),
        .wdata     (rt_value),
        .rdata     (dm_rdata),
        .test_addr (mem_addr[`DMEM_AW+1:2]),
        .test_data (mem_data)
    );

    // Write-back select
    assign rf_waddr = wdest_rd ? rd : rt;
    assign rf_wdata = wb_from_mem ? dm_rdata : alu_result;

    assign cpu_pc   = pc;
    assign cpu_inst = inst;

endmodule

/* logic/data_ram.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module data_ram (
    input  logic                clk,
    input  logic                wen,
    input  logic [`DMEM_AW-1:0] addr,
    input  logic [31:0]         wdata,
    output logic [31:0]         rdata,
    input  logic [`DMEM_AW-1:0] test_addr,
    output logic [31:0]         test_data
);

    logic [31:0] mem [0:`DMEM_DEPTH-1];    // Starts unknown

    // Whole-word write only
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata     = mem[addr];         // Load path
    assign test_data = mem[test_addr];    // Display port

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpu_ctrl_pkg::alu_op_e alu_op,
    input  logic [31:0]           src1,
    input  logic [31:0]           src2,
    output logic [31:0]           result
);

    logic [4:0] shamt;
    logic       less_than;

    assign shamt     = src1[4:0];
    assign less_than = ($signed(src1) < $signed(src2));

    always_comb begin
        case (alu_op)
            cpu_ctrl_pkg::ADD: begin
                result = src1 + src2;    // Wraps, no overflow trap
            end
            cpu_ctrl_pkg::SUB: begin
                result = src1 - src2;
            end
            cpu_ctrl_pkg::SLT: begin
                result = {31'd0, less_than};
            end
            cpu_ctrl_pkg::AND: result = src1 & src2;
            cpu_ctrl_pkg::NOR: result = ~(src1 | src2);
            cpu_ctrl_pkg::OR:  result = src1 | src2;
            cpu_ctrl_pkg::XOR: result = src1 ^ src2;
            cpu_ctrl_pkg::SLL: begin
                result = src2 << shamt;    // Shift src2 by src1
            end
            cpu_ctrl_pkg::SRL: begin
                result = src2 >> shamt;    // Logical, zero fill
            end
            cpu_ctrl_pkg::LUI: begin
                result = {src2[15:0], 16'd0};
            end
            default: begin
                result = 32'd0;
            end
        endcase
    end

endmodule

/* logic/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic        clk,
    input  logic        resetn,
    input  logic        wen,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic [4:0]  test_addr,
    output logic [31:0] test_data
);

    logic [31:0] regs [1:31];    // No storage for register zero

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wen && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;    // Writes to zero are dropped
        end
    end

    // Combinational reads, register zero hardwired
    assign rdata1    = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2    = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];
    assign test_data = (test_addr == 5'd0) ? 32'd0 : regs[test_addr];    // Display port

endmodule

/* logic/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  logic [31:0]           inst,
    output logic [4:0]            rs,
    output logic [4:0]            rt,
    output logic [4:0]            rd,
    output logic [4:0]            sa,
    output logic [15:0]           imm,
    output cpu_ctrl_pkg::alu_op_e alu_op,
    output logic                  src1_is_sa,
    output logic                  src2_is_imm,
    output logic                  rf_wen,
    output logic                  wdest_rd,
    output logic                  wb_from_mem,
    output logic                  mem_wen,
    output cpu_ctrl_pkg::pc_sel_e pc_sel
);

    logic [5:0] op;
    logic [5:0] funct;
    logic       sa_zero;
    logic       rs_zero;

    assign op    = inst[31:26];
    assign rs    = inst[25:21];
    assign rt    = inst[20:16];
    assign rd    = inst[15:11];
    assign sa    = inst[10:6];
    assign funct = inst[5:0];
    assign imm   = inst[15:0];

    assign sa_zero = (sa == 5'd0);    // Required by non-shift R-type
    assign rs_zero = (rs == 5'd0);    // Required by SLL and SRL

    always_comb begin
        alu_op      = cpu_ctrl_pkg::NONE;    // Unknown words act as no-ops
        src1_is_sa  = 1'b0;
        src2_is_imm = 1'b0;
        rf_wen      = 1'b0;
        wdest_rd    = 1'b0;
        wb_from_mem = 1'b0;
        mem_wen     = 1'b0;
        pc_sel      = cpu_ctrl_pkg::SEQ;
        case (op)
            mips_isa_pkg::SPECIAL: begin
                case (funct)
                    mips_isa_pkg::ADDU: if (sa_zero) alu_op = cpu_ctrl_pkg::ADD;
                    mips_isa_pkg::SUBU: if (sa_zero) alu_op = cpu_ctrl_pkg::SUB;
                    mips_isa_pkg::SLT:  if (sa_zero) alu_op = cpu_ctrl_pkg::SLT;
                    mips_isa_pkg::AND:  if (sa_zero) alu_op = cpu_ctrl_pkg::AND;
                    mips_isa_pkg::NOR:  if (sa_zero) alu_op = cpu_ctrl_pkg::NOR;
                    mips_isa_pkg::OR:   if (sa_zero) alu_op = cpu_ctrl_pkg::OR;
                    mips_isa_pkg::XOR:  if (sa_zero) alu_op = cpu_ctrl_pkg::XOR;
                    mips_isa_pkg::SLL:  if (rs_zero) alu_op = cpu_ctrl_pkg::SLL;
                    mips_isa_pkg::SRL:  if (rs_zero) alu_op = cpu_ctrl_pkg::SRL;
                    default: alu_op = cpu_ctrl_pkg::NONE;
                endcase
                src1_is_sa = (alu_op == cpu_ctrl_pkg::SLL) || (alu_op == cpu_ctrl_pkg::SRL);
                rf_wen     = (alu_op != cpu_ctrl_pkg::NONE);    // Only matched R-type writes
                wdest_rd   = 1'b1;
            end
            mips_isa_pkg::ADDIU: begin
                alu_op      = cpu_ctrl_pkg::ADD;
                src2_is_imm = 1'b1;
                rf_wen      = 1'b1;
            end
            mips_isa_pkg::LUI: begin
                alu_op      = cpu_ctrl_pkg::LUI;
                src2_is_imm = 1'b1;
                rf_wen      = 1'b1;
            end
            mips_isa_pkg::LW: begin
                alu_op      = cpu_ctrl_pkg::ADD;    // Base plus offset
                src2_is_imm = 1'b1;
                rf_wen      = 1'b1;
                wb_from_mem = 1'b1;
            end
            mips_isa_pkg::SW: begin
                alu_op      = cpu_ctrl_pkg::ADD;
                src2_is_imm = 1'b1;
                mem_wen     = 1'b1;
            end
            mips_isa_pkg::BEQ: pc_sel = cpu_ctrl_pkg::BEQ;
            mips_isa_pkg::BNE: pc_sel = cpu_ctrl_pkg::BNE;
            mips_isa_pkg::J:   pc_sel = cpu_ctrl_pkg::JUMP;
            default: pc_sel = cpu_ctrl_pkg::SEQ;
        endcase
    end

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  imem_wen,
    input  logic [`IMEM_AW-1:0]   imem_waddr,
    input  logic [31:0]           imem_wdata,
    input  cpu_ctrl_pkg::pc_sel_e pc_sel,
    input  logic [31:0]           rs_value,
    input  logic [31:0]           rt_value,
    output logic [31:0]           pc,
    output logic [31:0]           inst
);

    logic [31:0] imem [0:`IMEM_DEPTH-1];
    logic [31:0] seq_pc;
    logic [31:0] br_target;
    logic [31:0] j_target;
    logic [31:0] next_pc;
    logic        operands_equal;

    // Program load port
    always_ff @(posedge clk) begin
        if (imem_wen) begin
            imem[imem_waddr] <= imem_wdata;
        end
    end

    assign inst = imem[pc[`IMEM_AW+1:2]];    // Combinational fetch

    assign seq_pc    = pc + 32'd4;
    assign br_target = pc + {{14{inst[15]}}, inst[15:0], 2'b00};    // No delay slot
    assign j_target  = {pc[31:28], inst[25:0], 2'b00};

    assign operands_equal = (rs_value == rt_value);

    always_comb begin
        case (pc_sel)
            cpu_ctrl_pkg::SEQ: begin
                next_pc = seq_pc;
            end
            cpu_ctrl_pkg::BEQ: begin
                next_pc = operands_equal ? br_target : seq_pc;
            end
            cpu_ctrl_pkg::BNE: begin
                next_pc = operands_equal ? seq_pc : br_target;
            end
            cpu_ctrl_pkg::JUMP: begin
                next_pc = j_target;
            end
            default: begin
                next_pc = seq_pc;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= `STARTADDR;    // Held through reset
        end else begin
            pc <= next_pc;
        end
    end

endmodule

/* logic/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    // Operation selected in the ALU
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLT  = 4'd2,
        AND  = 4'd3,
        NOR  = 4'd4,
        OR   = 4'd5,
        XOR  = 4'd6,
        SLL  = 4'd7,
        SRL  = 4'd8,
        LUI  = 4'd9,
        NONE = 4'd15            // Result forced to zero
    } alu_op_e;

    // Kind of next-PC computation
    typedef enum logic [1:0] {
        SEQ  = 2'd0,            // PC+4
        BEQ  = 2'd1,            // Branch if equal
        BNE  = 2'd2,            // Branch if not equal
        JUMP = 2'd3             // Region jump
    } pc_sel_e;

endpackage

/* logic/mips_isa_pkg.sv */
package mips_isa_pkg;

    // Primary opcode field, inst[31:26]
    typedef enum logic [5:0] {
        SPECIAL = 6'b000000,    // R-type, see funct
        J       = 6'b000010,
        BEQ     = 6'b000100,
        BNE     = 6'b000101,
        ADDIU   = 6'b001001,
        LUI     = 6'b001111,
        LW      = 6'b100011,
        SW      = 6'b101011
    } opcode_e;

    // Function field of SPECIAL, inst[5:0]
    typedef enum logic [5:0] {
        SLL  = 6'b000000,       // Shift by sa
        SRL  = 6'b000010,       // Shift by sa
        ADDU = 6'b100001,
        SUBU = 6'b100011,
        AND  = 6'b100100,
        OR   = 6'b100101,
        XOR  = 6'b100110,
        NOR  = 6'b100111,
        SLT  = 6'b101010        // Signed compare
    } funct_e;

endpackage

/* include/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Reset vector of the program counter
`define STARTADDR 32'h0000_0000

// Instruction memory geometry
`define IMEM_DEPTH 32
`define IMEM_AW 5

// Data memory geometry
`define DMEM_DEPTH 32
`define DMEM_AW 5

// Word index of a byte address is taken from bit 2 up,
// so a memory of 2**AW words decodes address bits AW+1 down to 2

`endif
